// ==== rtl/issue_pkg.sv ====
package issue_pkg;

    // ----------------------------------------------------------
    // sizes
    // ----------------------------------------------------------
    localparam int unsigned XLEN            = 32;
    localparam int unsigned NR_REGS         = 32;
    // commit stage retires up to two results per cycle
    localparam int unsigned NR_COMMIT_PORTS = 2;
    localparam int unsigned TRANS_ID_BITS   = 3;

    // ----------------------------------------------------------
    // plain vectors
    // ----------------------------------------------------------
    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic [4:0]               reg_addr_t;
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
    // operation code, opaque to this stage
    typedef logic [5:0]               op_t;

    // functional unit, NONE must stay at zero so a cleared payload reads as no unit
    typedef enum logic [2:0] {
        NONE      = 3'd0,
        ALU       = 3'd1,
        CTRL_FLOW = 3'd2,
        MULT      = 3'd3,
        LOAD      = 3'd4,
        STORE     = 3'd5,
        CSR       = 3'd6
    } fu_t;

    // entry r names the unit that will write register r
    typedef fu_t [NR_REGS-1:0] clobber_t;

    // ----------------------------------------------------------
    // structs
    // ----------------------------------------------------------
    typedef struct packed {
        xlen_t     pc;
        trans_id_t trans_id;
        fu_t       fu;
        op_t       op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        xlen_t     imm;
        logic      use_imm;
        logic      use_pc;
        // rs1 field is a csr immediate
        logic      use_zimm;
        // exception raised earlier in the pipe
        logic      ex_valid;
    } issue_instr_t;

    // scoreboard forwarding answer
    typedef struct packed {
        xlen_t data;
        logic  valid;
    } sb_operand_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        xlen_t     wdata;
    } commit_port_t;

    typedef commit_port_t [NR_COMMIT_PORTS-1:0] commit_t;

    // payload handed to the execute stage
    typedef struct packed {
        fu_t       fu;
        op_t       op;
        xlen_t     operand_a;
        xlen_t     operand_b;
        xlen_t     imm;
        trans_id_t trans_id;
    } fu_data_t;

    typedef struct packed {
        logic alu;
        logic branch;
        logic mult;
        logic lsu;
        logic csr;
    } unit_valid_t;

endpackage

// ==== rtl/int_regfile.sv ====
`timescale 1ns/100ps

module int_regfile (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  issue_pkg::reg_addr_t  raddr_a_i,
    input  issue_pkg::reg_addr_t  raddr_b_i,
    output issue_pkg::xlen_t      rdata_a_o,
    output issue_pkg::xlen_t      rdata_b_o,
    input  issue_pkg::commit_t    commit_i
);

    // x0 is not stored at all
    issue_pkg::xlen_t regs_q [issue_pkg::NR_REGS-1:1];

    // ----------------------------------------------------------
    // write side
    // ----------------------------------------------------------
    // ports are visited in order, so the last matching port overrides
    // the earlier ones and port 1 wins a same-address write
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int unsigned r = 1; r < issue_pkg::NR_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int unsigned r = 1; r < issue_pkg::NR_REGS; r++) begin
                for (int unsigned p = 0; p < issue_pkg::NR_COMMIT_PORTS; p++) begin
                    if (commit_i[p].we && commit_i[p].waddr == issue_pkg::reg_addr_t'(r)) begin
                        regs_q[r] <= commit_i[p].wdata;
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------
    // read side
    // ----------------------------------------------------------
    // address 0 matches no entry and falls through to zero
    always_comb begin
        rdata_a_o = '0;
        rdata_b_o = '0;
        for (int unsigned r = 1; r < issue_pkg::NR_REGS; r++) begin
            if (raddr_a_i == issue_pkg::reg_addr_t'(r)) begin
                rdata_a_o = regs_q[r];
            end
            if (raddr_b_i == issue_pkg::reg_addr_t'(r)) begin
                rdata_b_o = regs_q[r];
            end
        end
    end

    // x0 reads as zero on both ports
    x0_reads_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ((raddr_a_i == '0) |-> (rdata_a_o == '0)) and ((raddr_b_i == '0) |-> (rdata_b_o == '0)))
        else $error("x0 returned non-zero data");

endmodule

// ==== rtl/operand_hazard_check.sv ====
`timescale 1ns/100ps

module operand_hazard_check (
    input  issue_pkg::issue_instr_t issue_instr_i,
    input  logic                    issue_valid_i,
    input  issue_pkg::sb_operand_t  rs1_i,
    input  issue_pkg::sb_operand_t  rs2_i,
    input  issue_pkg::clobber_t     rd_clobber_i,
    input  issue_pkg::commit_t      commit_i,
    input  logic                    flu_ready_i,
    input  logic                    lsu_ready_i,
    input  logic                    mult_pending_i,
    output issue_pkg::reg_addr_t    rs1_o,
    output issue_pkg::reg_addr_t    rs2_o,
    output logic                    forward_rs1_o,
    output logic                    forward_rs2_o,
    output logic                    issue_ack_o
);

    // a source operand is neither in the regfile nor forwardable yet
    logic stall;
    // the unit this instruction needs cannot take it
    logic fu_busy;
    // units that will write the two sources and the destination
    issue_pkg::fu_t rs1_owner;
    issue_pkg::fu_t rs2_owner;
    issue_pkg::fu_t rd_owner;

    // scoreboard lookup addresses
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    assign rs1_owner = rd_clobber_i[issue_instr_i.rs1];
    assign rs2_owner = rd_clobber_i[issue_instr_i.rs2];
    assign rd_owner  = rd_clobber_i[issue_instr_i.rd];

    // ----------------------------------------------------------
    // forwarding and stall
    // ----------------------------------------------------------
    always_comb begin : operands_available
        stall         = 1'b0;
        forward_rs1_o = 1'b0;
        forward_rs2_o = 1'b0;
        // zimm carries an immediate in the rs1 field, no dependency there
        if (!issue_instr_i.use_zimm && rs1_owner != issue_pkg::NONE) begin
            // csr results only ever come back through the regfile
            if (rs1_i.valid && rs1_owner != issue_pkg::CSR) begin
                forward_rs1_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (rs2_owner != issue_pkg::NONE) begin
            if (rs2_i.valid && rs2_owner != issue_pkg::CSR) begin
                forward_rs2_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // busy select
    // ----------------------------------------------------------
    always_comb begin : unit_busy
        case (issue_instr_i.fu)
            issue_pkg::ALU, issue_pkg::CTRL_FLOW, issue_pkg::MULT, issue_pkg::CSR:
                fu_busy = ~flu_ready_i;
            issue_pkg::LOAD, issue_pkg::STORE:
                fu_busy = ~lsu_ready_i;
            default:
                fu_busy = 1'b0;
        endcase
    end

    // ----------------------------------------------------------
    // issue decision
    // ----------------------------------------------------------
    always_comb begin : issue_decision
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!stall && !fu_busy) begin
                // waw check, rd has no pending writer
                if (rd_owner == issue_pkg::NONE) begin
                    issue_ack_o = 1'b1;
                end
                // or the pending writer retires rd right now
                for (int unsigned p = 0; p < issue_pkg::NR_COMMIT_PORTS; p++) begin
                    if (commit_i[p].we && commit_i[p].waddr == issue_instr_i.rd) begin
                        issue_ack_o = 1'b1;
                    end
                end
            end
            // exceptions and unit-less instructions pass without any check
            if (issue_instr_i.ex_valid || issue_instr_i.fu == issue_pkg::NONE) begin
                issue_ack_o = 1'b1;
            end
        end
        // the multiplier shares the fixed latency result bus, so only
        // another multiply may follow it back to back
        if (mult_pending_i && issue_instr_i.fu != issue_pkg::MULT) begin
            issue_ack_o = 1'b0;
        end
        ack_needs_valid: assert (!issue_ack_o || issue_valid_i)
            else $error("issue acknowledged without a valid instruction");
    end

endmodule

// ==== rtl/operand_select.sv ====
`timescale 1ns/100ps

module operand_select (
    input  issue_pkg::issue_instr_t issue_instr_i,
    input  issue_pkg::xlen_t        rf_a_i,
    input  issue_pkg::xlen_t        rf_b_i,
    input  issue_pkg::sb_operand_t  rs1_i,
    input  issue_pkg::sb_operand_t  rs2_i,
    input  logic                    forward_rs1_i,
    input  logic                    forward_rs2_i,
    output issue_pkg::fu_data_t     payload_o
);

    // ----------------------------------------------------------
    // forwarding and override mux
    // ----------------------------------------------------------
    always_comb begin : operand_mux
        // fields that pass straight through
        payload_o.fu       = issue_instr_i.fu;
        payload_o.op       = issue_instr_i.op;
        payload_o.trans_id = issue_instr_i.trans_id;
        // stores keep their offset here, branches their target offset
        payload_o.imm      = issue_instr_i.imm;

        // operand a, regfile or scoreboard first
        payload_o.operand_a = forward_rs1_i ? rs1_i.data : rf_a_i;
        // auipc and jal style use of the pc
        if (issue_instr_i.use_pc) begin
            payload_o.operand_a = issue_instr_i.pc;
        end
        // zero extended csr immediate, checked last so it wins over pc
        if (issue_instr_i.use_zimm) begin
            payload_o.operand_a = issue_pkg::xlen_t'(issue_instr_i.rs1);
        end

        // operand b
        payload_o.operand_b = forward_rs2_i ? rs2_i.data : rf_b_i;
        // store data and branch compare value must stay in operand b
        if (issue_instr_i.use_imm
            && issue_instr_i.fu != issue_pkg::STORE
            && issue_instr_i.fu != issue_pkg::CTRL_FLOW) begin
            payload_o.operand_b = issue_instr_i.imm;
        end
    end

endmodule

// ==== rtl/issue_register.sv ====
`timescale 1ns/100ps

module issue_register (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    issue_valid_i,
    input  logic                    issue_ack_i,
    input  issue_pkg::issue_instr_t issue_instr_i,
    input  issue_pkg::fu_data_t     payload_i,
    output issue_pkg::fu_data_t     fu_data_o,
    output issue_pkg::unit_valid_t  unit_valid_o,
    output logic                    mult_pending_o
);

    issue_pkg::unit_valid_t unit_valid_n;
    issue_pkg::unit_valid_t unit_valid_q;
    issue_pkg::fu_data_t    payload_q;

    // ----------------------------------------------------------
    // unit strobe decode
    // ----------------------------------------------------------
    always_comb begin : unit_valid
        unit_valid_n = '0;
        // an instruction carrying an exception is acknowledged but
        // never reaches a unit
        if (!issue_instr_i.ex_valid && issue_valid_i && issue_ack_i) begin
            case (issue_instr_i.fu)
                issue_pkg::ALU:
                    unit_valid_n.alu = 1'b1;
                issue_pkg::CTRL_FLOW:
                    unit_valid_n.branch = 1'b1;
                issue_pkg::MULT:
                    unit_valid_n.mult = 1'b1;
                issue_pkg::LOAD, issue_pkg::STORE:
                    unit_valid_n.lsu = 1'b1;
                issue_pkg::CSR:
                    unit_valid_n.csr = 1'b1;
                default:
                    unit_valid_n = '0;
            endcase
        end
        // a flush kills the strobe so no unit starts on stale operands
        if (flush_i) begin
            unit_valid_n = '0;
        end
    end

    // ----------------------------------------------------------
    // issue to execute registers
    // ----------------------------------------------------------
    // payload follows the issue port every cycle, the strobes qualify it
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            payload_q    <= '0;
            unit_valid_q <= '0;
        end else begin
            payload_q    <= payload_i;
            unit_valid_q <= unit_valid_n;
        end
    end

    assign fu_data_o      = payload_q;
    assign unit_valid_o   = unit_valid_q;
    // fed back to hold off non-multiply issue
    assign mult_pending_o = unit_valid_q.mult;

    // single issue, so never two units started at once
    one_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(unit_valid_q))
        else $error("more than one unit strobe raised");

endmodule

// ==== rtl/issue_read_operands.sv ====
`timescale 1ns/100ps

module issue_read_operands (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    // upstream issue port
    input  issue_pkg::issue_instr_t issue_instr_i,
    input  logic                    issue_valid_i,
    output logic                    issue_ack_o,
    // scoreboard lookup
    output issue_pkg::reg_addr_t    rs1_o,
    output issue_pkg::reg_addr_t    rs2_o,
    input  issue_pkg::sb_operand_t  rs1_i,
    input  issue_pkg::sb_operand_t  rs2_i,
    input  issue_pkg::clobber_t     rd_clobber_i,
    // commit write ports
    input  issue_pkg::commit_t      commit_i,
    // unit readiness
    input  logic                    flu_ready_i,
    input  logic                    lsu_ready_i,
    // to execute
    output issue_pkg::fu_data_t     fu_data_o,
    output issue_pkg::unit_valid_t  unit_valid_o
);

    issue_pkg::xlen_t    rf_a;
    issue_pkg::xlen_t    rf_b;
    logic                forward_rs1;
    logic                forward_rs2;
    logic                mult_pending;
    issue_pkg::fu_data_t payload_n;

    // ----------------------------------------------------------
    // integer register file
    // ----------------------------------------------------------
    int_regfile i_int_regfile (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .raddr_a_i (issue_instr_i.rs1),
        .raddr_b_i (issue_instr_i.rs2),
        .rdata_a_o (rf_a),
        .rdata_b_o (rf_b),
        .commit_i  (commit_i)
    );

    // hazards, forwarding decision and acknowledge
    operand_hazard_check i_operand_hazard_check (
        .issue_instr_i  (issue_instr_i),
        .issue_valid_i  (issue_valid_i),
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .rd_clobber_i   (rd_clobber_i),
        .commit_i       (commit_i),
        .flu_ready_i    (flu_ready_i),
        .lsu_ready_i    (lsu_ready_i),
        .mult_pending_i (mult_pending),
        .rs1_o          (rs1_o),
        .rs2_o          (rs2_o),
        .forward_rs1_o  (forward_rs1),
        .forward_rs2_o  (forward_rs2),
        .issue_ack_o    (issue_ack_o)
    );

    operand_select i_operand_select (
        .issue_instr_i (issue_instr_i),
        .rf_a_i        (rf_a),
        .rf_b_i        (rf_b),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .forward_rs1_i (forward_rs1),
        .forward_rs2_i (forward_rs2),
        .payload_o     (payload_n)
    );

    // pipeline register towards the units
    issue_register i_issue_register (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .issue_valid_i  (issue_valid_i),
        .issue_ack_i    (issue_ack_o),
        .issue_instr_i  (issue_instr_i),
        .payload_i      (payload_n),
        .fu_data_o      (fu_data_o),
        .unit_valid_o   (unit_valid_o),
        .mult_pending_o (mult_pending)
    );

endmodule

// ==== verification/clock_gen.sv ====
`timescale 1ns/100ps

module clock_gen (
    output logic clk_o,
    output logic rst_no
);

    // 20 ns period
    localparam real         HALF_PERIOD  = 10.0;
    localparam int unsigned RESET_CYCLES = 4;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // reset held for the first cycles, released on a falling edge
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

// ==== verification/tb_issue_read_operands.sv ====
`timescale 1ns/100ps

module tb_issue_read_operands;

    localparam int unsigned CYCLES_PER_TEST = 200;
    localparam int unsigned NUM_TESTS       = 5;
    // each random test plus its idle cycle, reset and some slack
    localparam int unsigned TOTAL_CYCLES    = NUM_TESTS * (CYCLES_PER_TEST + 1) + 4 + 4;
    localparam real         WATCHDOG_NS     = 2.0 * 20.0 * TOTAL_CYCLES;

    logic                    clk;
    logic                    rst_n;
    logic                    flush;
    issue_pkg::issue_instr_t instr;
    logic                    valid;
    logic                    ack;
    issue_pkg::reg_addr_t    rs1_addr;
    issue_pkg::reg_addr_t    rs2_addr;
    issue_pkg::sb_operand_t  sb1;
    issue_pkg::sb_operand_t  sb2;
    issue_pkg::clobber_t     clob;
    issue_pkg::commit_t      commit;
    logic                    flu_ready;
    logic                    lsu_ready;
    issue_pkg::fu_data_t     fu_data;
    issue_pkg::unit_valid_t  unit_valid;

    // reference model state
    issue_pkg::xlen_t        shadow [issue_pkg::NR_REGS];
    logic                    model_pending;
    logic                    exp_ready;
    issue_pkg::fu_data_t     exp_data;
    issue_pkg::unit_valid_t  exp_uv;

    integer      seed;
    int unsigned errors;
    int unsigned total_checks;
    int unsigned test_errors;
    int unsigned test_checks;
    string       test_name;

    clock_gen i_clock_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    issue_read_operands uut (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .flush_i       (flush),
        .issue_instr_i (instr),
        .issue_valid_i (valid),
        .issue_ack_o   (ack),
        .rs1_o         (rs1_addr),
        .rs2_o         (rs2_addr),
        .rs1_i         (sb1),
        .rs2_i         (sb2),
        .rd_clobber_i  (clob),
        .commit_i      (commit),
        .flu_ready_i   (flu_ready),
        .lsu_ready_i   (lsu_ready),
        .fu_data_o     (fu_data),
        .unit_valid_o  (unit_valid)
    );

    // ----------------------------------------------------------
    // helpers
    // ----------------------------------------------------------
    function automatic int unsigned pick(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic check_value(string what, logic [127:0] expected, logic [127:0] actual);
        test_checks++;
        if (expected !== actual) begin
            test_errors++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    // registered outputs of the previous cycle, stable mid cycle
    task automatic check_outputs();
        if (exp_ready) begin
            check_value("fu_data", exp_data, fu_data);
            check_value("unit_valid", exp_uv, unit_valid);
        end
    endtask

    // id 0 idles, otherwise each test narrows the random stimulus
    task automatic randomize_inputs(int unsigned test_id);
        instr.pc       = $random(seed);
        instr.trans_id = 3'(pick(8));
        instr.fu       = issue_pkg::fu_t'(3'(pick(7)));
        instr.op       = 6'(pick(64));
        instr.rd       = 5'(pick(32));
        instr.rs1      = 5'(pick(32));
        instr.rs2      = 5'(pick(32));
        instr.imm      = $random(seed);
        instr.use_imm  = 1'(pick(2));
        instr.use_pc   = 1'(pick(2));
        instr.use_zimm = 1'(pick(2));
        instr.ex_valid = (pick(8) == 0);
        for (int r = 0; r < issue_pkg::NR_REGS; r++) begin
            clob[r] = (pick(2) == 0) ? issue_pkg::NONE : issue_pkg::fu_t'(3'(1 + pick(6)));
        end
        sb1.data  = $random(seed);
        sb1.valid = 1'(pick(2));
        sb2.data  = $random(seed);
        sb2.valid = 1'(pick(2));
        for (int p = 0; p < issue_pkg::NR_COMMIT_PORTS; p++) begin
            commit[p].we    = 1'(pick(2));
            commit[p].waddr = 5'(pick(32));
            commit[p].wdata = $random(seed);
        end
        valid     = (pick(4) != 0);
        flu_ready = (pick(4) != 0);
        lsu_ready = (pick(4) != 0);
        flush     = (pick(8) == 0);
        case (test_id)
            0: valid = 1'b0;
            // register file reads and same-address writes
            1: begin
                clob           = '0;
                flush          = 1'b0;
                instr.ex_valid = 1'b0;
                instr.use_imm  = 1'b0;
                instr.use_pc   = 1'b0;
                instr.use_zimm = 1'b0;
                if (pick(4) == 0) begin
                    commit[0].we    = 1'b1;
                    commit[1].we    = 1'b1;
                    commit[1].waddr = commit[0].waddr;
                end
                if (pick(8) == 0) begin
                    instr.rs1 = '0;
                end
            end
            // only the sources may be clobbered here
            2: begin
                for (int r = 0; r < issue_pkg::NR_REGS; r++) begin
                    if (5'(r) != instr.rs1 && 5'(r) != instr.rs2) begin
                        clob[r] = issue_pkg::NONE;
                    end
                end
                if (pick(4) == 0) begin
                    clob[instr.rs1] = issue_pkg::CSR;
                    sb1.valid       = 1'b1;
                end
                instr.use_imm  = 1'b0;
                instr.use_pc   = 1'b0;
                instr.use_zimm = 1'b0;
                instr.ex_valid = 1'b0;
                flush          = 1'b0;
                valid          = 1'b1;
                flu_ready      = 1'b1;
                lsu_ready      = 1'b1;
            end
            // operand overrides without hazards
            3: begin
                clob           = '0;
                flush          = 1'b0;
                instr.ex_valid = 1'b0;
                flu_ready      = 1'b1;
                lsu_ready      = 1'b1;
            end
            4: flush = 1'b0;
            default: ;
        endcase
    endtask

    // ----------------------------------------------------------
    // one cycle of stimulus, model and checks
    // ----------------------------------------------------------
    task automatic step(int unsigned test_id);
        issue_pkg::fu_t   own1;
        issue_pkg::fu_t   own2;
        issue_pkg::fu_t   own_rd;
        logic             fwd1;
        logic             fwd2;
        logic             stall;
        logic             rdy;
        logic             waw_ok;
        logic             exp_ack;
        issue_pkg::xlen_t a;
        issue_pkg::xlen_t b;
        @(negedge clk);
        check_outputs();
        randomize_inputs(test_id);
        #1;
        own1   = clob[instr.rs1];
        own2   = clob[instr.rs2];
        own_rd = clob[instr.rd];
        // a csr result is never forwarded, zimm has no rs1 dependency
        fwd1  = !instr.use_zimm && own1 != issue_pkg::NONE && sb1.valid
                && own1 != issue_pkg::CSR;
        fwd2  = own2 != issue_pkg::NONE && sb2.valid && own2 != issue_pkg::CSR;
        stall = (!instr.use_zimm && own1 != issue_pkg::NONE && !fwd1)
                || (own2 != issue_pkg::NONE && !fwd2);
        case (instr.fu)
            issue_pkg::LOAD, issue_pkg::STORE: rdy = lsu_ready;
            issue_pkg::NONE:                   rdy = 1'b1;
            default:                           rdy = flu_ready;
        endcase
        // rd free, or retired by a commit port right now
        waw_ok = (own_rd == issue_pkg::NONE);
        for (int p = 0; p < issue_pkg::NR_COMMIT_PORTS; p++) begin
            if (commit[p].we && commit[p].waddr == instr.rd) begin
                waw_ok = 1'b1;
            end
        end
        exp_ack = valid && ((!stall && rdy && waw_ok) || instr.ex_valid
                  || instr.fu == issue_pkg::NONE);
        if (model_pending && instr.fu != issue_pkg::MULT) begin
            exp_ack = 1'b0;
        end
        check_value("issue_ack", exp_ack, ack);
        check_value("rs1_o", instr.rs1, rs1_addr);
        check_value("rs2_o", instr.rs2, rs2_addr);

        // operand a starts from the source, then pc and zimm override it
        a = fwd1 ? sb1.data : shadow[instr.rs1];
        if (instr.use_pc) begin
            a = instr.pc;
        end
        if (instr.use_zimm) begin
            a = {27'b0, instr.rs1};
        end
        b = fwd2 ? sb2.data : shadow[instr.rs2];
        if (instr.use_imm && instr.fu != issue_pkg::STORE && instr.fu != issue_pkg::CTRL_FLOW) begin
            b = instr.imm;
        end
        exp_data.fu        = instr.fu;
        exp_data.op        = instr.op;
        exp_data.operand_a = a;
        exp_data.operand_b = b;
        exp_data.imm       = instr.imm;
        exp_data.trans_id  = instr.trans_id;

        exp_uv = '0;
        if (valid && exp_ack && !instr.ex_valid && !flush) begin
            case (instr.fu)
                issue_pkg::ALU:                    exp_uv.alu    = 1'b1;
                issue_pkg::CTRL_FLOW:              exp_uv.branch = 1'b1;
                issue_pkg::MULT:                   exp_uv.mult   = 1'b1;
                issue_pkg::LOAD, issue_pkg::STORE: exp_uv.lsu    = 1'b1;
                issue_pkg::CSR:                    exp_uv.csr    = 1'b1;
                default:                           exp_uv        = '0;
            endcase
        end
        model_pending = exp_uv.mult;
        exp_ready     = 1'b1;

        // commits land at the coming edge, port 1 last so it wins
        for (int p = 0; p < issue_pkg::NR_COMMIT_PORTS; p++) begin
            if (commit[p].we && commit[p].waddr != '0) begin
                shadow[commit[p].waddr] = commit[p].wdata;
            end
        end
    endtask

    task automatic run_test(string name, int unsigned test_id);
        test_name   = name;
        test_errors = 0;
        test_checks = 0;
        repeat (CYCLES_PER_TEST) step(test_id);
        step(0);
        $display("%s: %0d checks, %0d errors", test_name, test_checks, test_errors);
        errors       += test_errors;
        total_checks += test_checks;
    endtask

    // ----------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------
    initial begin
        seed          = 29;
        errors        = 0;
        total_checks  = 0;
        exp_ready     = 1'b0;
        model_pending = 1'b0;
        instr         = '0;
        valid         = 1'b0;
        flush         = 1'b0;
        sb1           = '0;
        sb2           = '0;
        clob          = '0;
        commit        = '0;
        flu_ready     = 1'b1;
        lsu_ready     = 1'b1;
        for (int r = 0; r < issue_pkg::NR_REGS; r++) begin
            shadow[r] = '0;
        end

        // outputs sampled at release, before any clock edge can load them
        @(posedge rst_n);
        test_name   = "reset";
        test_errors = 0;
        test_checks = 0;
        check_value("unit_valid", '0, unit_valid);
        check_value("fu_data", '0, fu_data);
        check_value("fu_data.fu", issue_pkg::NONE, fu_data.fu);
        $display("%s: %0d checks, %0d errors", test_name, test_checks, test_errors);
        errors       += test_errors;
        total_checks += test_checks;

        run_test("register_file", 1);
        run_test("forwarding", 2);
        run_test("operand_overrides", 3);
        run_test("issue_rules", 4);
        run_test("strobes_flush", 5);

        // last idle cycle still has its registered outputs pending
        test_errors = 0;
        test_checks = 0;
        @(negedge clk);
        check_outputs();
        errors       += test_errors;
        total_checks += test_checks;

        $display("checks: %0d, errors: %0d", total_checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // stop a run that never reaches its end
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== tb.f ====
rtl/issue_pkg.sv
rtl/int_regfile.sv
rtl/operand_hazard_check.sv
rtl/operand_select.sv
rtl/issue_register.sv
rtl/issue_read_operands.sv
verification/clock_gen.sv
verification/tb_issue_read_operands.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_issue_read_operands
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
